// File: fp_fmt_pkg.sv
// ---------------------------------------------------------------------
// Floating-point format definitions for the SIMD slice.
// Holds the datapath width, the lane word union, canonical NaNs and
// small NaN classifiers. Imported by the RTL and by the testbench.
// ---------------------------------------------------------------------
`default_nettype none

package fp_fmt_pkg;

  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // One operand word, read as a single FP32 or as two FP16 values
  typedef union packed {
    logic [SLICE_WIDTH-1:0]                          fp32;
    logic [NUM_LANES-1:0][SLICE_WIDTH/NUM_LANES-1:0] fp16;  // Lane 0 in the low half
  } fp_word_u;

  localparam logic [31:0] FP32_QNAN = 32'h7fc0_0000;
  localparam logic [15:0] FP16_QNAN = 16'h7e00;
  localparam logic [15:0] FP16_BOX  = 16'hffff;  // Fills unused upper bits

  // ---------------------------------------------------------------------
  // NaN classifiers
  // ---------------------------------------------------------------------
  function automatic logic fp32_is_nan(logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic fp32_is_snan(logic [31:0] x);
    return fp32_is_nan(x) && !x[22];  // Quiet bit clear
  endfunction

  function automatic logic fp16_is_nan(logic [15:0] x);
    return (x[14:10] == 5'h1f) && (x[9:0] != 10'd0);
  endfunction

  function automatic logic fp16_is_snan(logic [15:0] x);
    return fp16_is_nan(x) && !x[9];
  endfunction

endpackage

`default_nettype wire

// File: fp_op_pkg.sv
// ---------------------------------------------------------------------
// Operation encoding and status flags of the non-computational group.
// Shared by the lanes, the slice top level and the testbench.
// ---------------------------------------------------------------------
`default_nettype none

package fp_op_pkg;

  // Sign injection and min/max operations
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } fp_op_e;

  // IEEE 754 exception flags, same order as the RISC-V fflags CSR
  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // Side-band bits carried next to the lane data: {format, vector}
  localparam int unsigned AUX_BITS = 2;

endpackage

`default_nettype wire

// File: fp_pipe.sv
// ---------------------------------------------------------------------
// Elastic pipeline with valid/ready flow control.
// Each stage holds one payload word; empty stages let data move up,
// so bubbles collapse. Zero stages gives a combinational path.
// ---------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module fp_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned DataWidth   = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [DataWidth-1:0] data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 busy_o
);

  if (NumPipeRegs == 0) begin : gen_bypass
    assign out_valid_o = in_valid_i;
    assign in_ready_o  = out_ready_i;
    assign data_o      = data_i;
    assign busy_o      = 1'b0;  // Nothing is ever held
  end else begin : gen_stages
    logic [NumPipeRegs-1:0]                valid_q;
    logic [NumPipeRegs-1:0][DataWidth-1:0] data_q;
    logic [NumPipeRegs-1:0]                stage_ready;     // Stage i takes new data
    logic [NumPipeRegs-1:0]                stage_in_valid;
    logic [NumPipeRegs-1:0][DataWidth-1:0] stage_in_data;

    always_comb begin : chain
      stage_in_valid[0] = in_valid_i;
      stage_in_data[0]  = data_i;
      for (int i = 1; i < NumPipeRegs; i++) begin
        stage_in_valid[i] = valid_q[i-1];
        stage_in_data[i]  = data_q[i-1];
      end
      // Ready ripples back from the output
      stage_ready[NumPipeRegs-1] = ~valid_q[NumPipeRegs-1] | out_ready_i;
      for (int i = NumPipeRegs - 2; i >= 0; i--) begin
        stage_ready[i] = ~valid_q[i] | stage_ready[i+1];
      end
    end

    always_ff @(posedge clk_i) begin : stage_valid
      if (!rst_n_i) begin
        valid_q <= '0;
      end else begin
        for (int i = 0; i < NumPipeRegs; i++) begin
          if (stage_ready[i]) valid_q[i] <= stage_in_valid[i];
        end
      end
    end

    always_ff @(posedge clk_i) begin : stage_data
      for (int i = 0; i < NumPipeRegs; i++) begin
        if (stage_ready[i] && stage_in_valid[i]) data_q[i] <= stage_in_data[i];
      end
    end

    assign in_ready_o  = stage_ready[0];
    assign out_valid_o = valid_q[NumPipeRegs-1];
    assign data_o      = data_q[NumPipeRegs-1];
    assign busy_o      = |valid_q;
  end

  // Held output keeps both its valid and its data until taken
  a_out_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o));

endmodule

`default_nettype wire

// File: fp_noncomp_lane.sv
// ---------------------------------------------------------------------
// One lane of the non-computational group: sign injection and min/max.
// The operation is combinational and its result, flags and aux bits
// then pass through an elastic pipeline. A 32-bit lane also handles
// scalar FP16 and NaN-boxes it; a 16-bit lane is FP16 only.
// ---------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module fp_noncomp_lane #(
  parameter int unsigned LaneWidth   = 32,
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  fp_op_pkg::fp_op_e              op_i,
  input  fp_fmt_pkg::fp_fmt_e            fmt_i,
  input  logic [LaneWidth-1:0]           operand_a_i,
  input  logic [LaneWidth-1:0]           operand_b_i,
  input  logic [fp_op_pkg::AUX_BITS-1:0] aux_i,
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  output logic [LaneWidth-1:0]           result_o,
  output fp_op_pkg::status_t             status_o,
  output logic [fp_op_pkg::AUX_BITS-1:0] aux_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic                           busy_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  localparam int unsigned PayloadWidth = LaneWidth + $bits(status_t) + AUX_BITS;

  logic                    use_fp16;
  logic [31:0]             a_w, b_w;        // Operands widened to the FP32 view
  logic                    sign_a, sign_b;
  logic [30:0]             mag_a, mag_b;
  logic                    nan_a, nan_b, snan_a, snan_b;
  logic [31:0]             canon_nan;
  logic                    a_lt_b;
  logic [31:0]             raw_res, res_w;
  logic [LaneWidth-1:0]    op_result;
  status_t                 op_status;
  logic [PayloadWidth-1:0] payload_in, payload_out;

  assign use_fp16 = (LaneWidth == 16) || (fmt_i == FP16);
  assign a_w      = 32'(operand_a_i);
  assign b_w      = 32'(operand_b_i);

  // Pick sign, magnitude and NaN class for the active format
  always_comb begin : decode_operands
    if (use_fp16) begin
      sign_a    = a_w[15];
      sign_b    = b_w[15];
      mag_a     = 31'(a_w[14:0]);
      mag_b     = 31'(b_w[14:0]);
      nan_a     = fp16_is_nan(a_w[15:0]);
      nan_b     = fp16_is_nan(b_w[15:0]);
      snan_a    = fp16_is_snan(a_w[15:0]);
      snan_b    = fp16_is_snan(b_w[15:0]);
      canon_nan = 32'(FP16_QNAN);  // Boxed below
    end else begin
      sign_a    = a_w[31];
      sign_b    = b_w[31];
      mag_a     = a_w[30:0];
      mag_b     = b_w[30:0];
      nan_a     = fp32_is_nan(a_w);
      nan_b     = fp32_is_nan(b_w);
      snan_a    = fp32_is_snan(a_w);
      snan_b    = fp32_is_snan(b_w);
      canon_nan = FP32_QNAN;
    end
  end

  // Signed-magnitude order, so -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a
                                     : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

  always_comb begin : compute
    logic new_sign;
    new_sign  = sign_b;
    raw_res   = a_w;
    op_status = '0;
    case (op_i)
      SGNJ:  new_sign = sign_b;
      SGNJN: new_sign = ~sign_b;
      SGNJX: new_sign = sign_a ^ sign_b;
      default: begin  // MIN and MAX
        if (nan_a && nan_b)  raw_res = canon_nan;
        else if (nan_a)      raw_res = b_w;  // Non-NaN input wins
        else if (nan_b)      raw_res = a_w;
        else                 raw_res = ((op_i == MIN) == a_lt_b) ? a_w : b_w;
        op_status.NV = snan_a | snan_b;
      end
    endcase
    if (op_i inside {SGNJ, SGNJN, SGNJX}) begin
      if (use_fp16) raw_res[15] = new_sign;
      else          raw_res[31] = new_sign;
    end
  end

  assign res_w     = use_fp16 ? {FP16_BOX, raw_res[15:0]} : raw_res;
  assign op_result = res_w[LaneWidth-1:0];

  // ---------------------------------------------------------------------
  // Output pipeline
  // ---------------------------------------------------------------------
  assign payload_in = {aux_i, op_status, op_result};

  fp_pipe #(
    .NumPipeRegs ( NumPipeRegs  ),
    .DataWidth   ( PayloadWidth )
  ) i_fp_pipe (
    .clk_i,
    .rst_n_i,
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .data_i      ( payload_in  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .data_o      ( payload_out ),
    .busy_o      ( busy_o      )
  );

  assign {aux_o, status_o, result_o} = payload_out;

  // Upper lanes only receive work from vector FP16 items
  a_lane_fmt : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> (LaneWidth == 32) || (fmt_i == FP16));

endmodule

`default_nettype wire

// File: fp_simd_slice.sv
// ---------------------------------------------------------------------
// Two-lane SIMD slice for sign injection and min/max.
// A 32-bit word carries one FP32 or two FP16 values. Lane 0 always
// runs, lane 1 only for vector FP16. Results are repacked by the
// format that travels with each item, and lane flags are OR-ed.
// ---------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module fp_simd_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  fp_op_pkg::fp_op_e    op_i,
  input  fp_fmt_pkg::fp_fmt_e  fmt_i,
  input  logic                 vectorial_i,
  input  fp_fmt_pkg::fp_word_u operand_a_i,
  input  fp_fmt_pkg::fp_word_u operand_b_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output fp_fmt_pkg::fp_word_u result_o,
  output fp_op_pkg::status_t   status_o,
  output logic                 busy_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  localparam int unsigned Fp16Width = SLICE_WIDTH / NUM_LANES;

  logic                 vector_op;
  logic [AUX_BITS-1:0]  aux_in;

  logic [NUM_LANES-1:0]               lane_in_valid, lane_in_ready;
  logic [NUM_LANES-1:0]               lane_out_valid, lane_out_ready;
  logic [NUM_LANES-1:0]               lane_busy;
  logic [NUM_LANES-1:0][AUX_BITS-1:0] lane_aux;
  status_t [NUM_LANES-1:0]            lane_status;
  logic [SLICE_WIDTH-1:0]             lane0_result;
  logic [Fp16Width-1:0]               lane1_result;

  fp_fmt_e result_fmt;
  logic    result_is_vector;

  // ---------------------------------------------------------------------
  // Input side
  // ---------------------------------------------------------------------
  assign vector_op = vectorial_i & (fmt_i == FP16);  // FP32 is never vectorial
  assign aux_in    = {fmt_i, vector_op};

  assign lane_in_valid[0] = in_valid_i;
  // Lane 1 only loads together with lane 0, so a stalled vector item is not taken twice
  assign lane_in_valid[1] = in_valid_i & vector_op & lane_in_ready[0];
  assign in_ready_o       = lane_in_ready[0];

  fp_noncomp_lane #(
    .LaneWidth   ( SLICE_WIDTH ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_lane0 (
    .clk_i,
    .rst_n_i,
    .op_i,
    .fmt_i,
    .operand_a_i ( operand_a_i.fp32  ),
    .operand_b_i ( operand_b_i.fp32  ),
    .aux_i       ( aux_in            ),
    .in_valid_i  ( lane_in_valid[0]  ),
    .in_ready_o  ( lane_in_ready[0]  ),
    .result_o    ( lane0_result      ),
    .status_o    ( lane_status[0]    ),
    .aux_o       ( lane_aux[0]       ),
    .out_valid_o ( lane_out_valid[0] ),
    .out_ready_i ( lane_out_ready[0] ),
    .busy_o      ( lane_busy[0]      )
  );

  fp_noncomp_lane #(
    .LaneWidth   ( Fp16Width   ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_lane1 (
    .clk_i,
    .rst_n_i,
    .op_i,
    .fmt_i,
    .operand_a_i ( operand_a_i.fp16[1] ),  // Upper FP16 value
    .operand_b_i ( operand_b_i.fp16[1] ),
    .aux_i       ( aux_in              ),
    .in_valid_i  ( lane_in_valid[1]    ),
    .in_ready_o  ( lane_in_ready[1]    ),
    .result_o    ( lane1_result        ),
    .status_o    ( lane_status[1]      ),
    .aux_o       ( lane_aux[1]         ),
    .out_valid_o ( lane_out_valid[1]   ),
    .out_ready_i ( lane_out_ready[1]   ),
    .busy_o      ( lane_busy[1]        )
  );

  // ---------------------------------------------------------------------
  // Output side
  // ---------------------------------------------------------------------
  assign result_fmt       = fp_fmt_e'(lane_aux[0][1]);
  assign result_is_vector = lane_aux[0][0];

  assign lane_out_ready[0] = out_ready_i;
  assign lane_out_ready[1] = out_ready_i & result_is_vector;
  assign out_valid_o       = lane_out_valid[0];
  assign busy_o            = |lane_busy;

  always_comb begin : pack_result
    result_o.fp32 = lane0_result;  // FP32, or scalar FP16 already boxed
    if (result_fmt == FP16 && result_is_vector) result_o.fp16[1] = lane1_result;
  end

  always_comb begin : collapse_status
    status_o = lane_status[0];
    if (result_is_vector) status_o = status_t'(status_o | lane_status[1]);
  end

  // Lanes stay in lockstep on entry and on exit
  a_vec_entry : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_in_valid[1] |-> lane_in_ready[1]);

  a_vec_exit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_out_valid[0] && result_is_vector |->
      lane_out_valid[1] && (lane_aux[1] == lane_aux[0]));

endmodule

`default_nettype wire

// File: fp_slice_checker.sv
// ---------------------------------------------------------------------
// Testbench checker for the SIMD slice.
// Watches the DUT ports, queues the expected word on every input
// transfer and compares it on every output transfer.
// ---------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module fp_slice_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  input  logic                 in_ready_i,
  input  fp_op_pkg::fp_op_e    op_i,
  input  fp_fmt_pkg::fp_fmt_e  fmt_i,
  input  logic                 vectorial_i,
  input  logic [31:0]          operand_a_i,
  input  logic [31:0]          operand_b_i,
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  logic [31:0]          result_i,
  input  fp_op_pkg::status_t   status_i,
  input  logic                 busy_i,
  output int                   errors_o,
  output int                   checked_o,
  output int                   pending_o
);
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  logic [36:0] expect_q[$];  // {status, result}

  // Returns {nv, result} for one lane value; half selects FP16 in bits 15:0
  function automatic logic [32:0] lane_ref(fp_op_e op, logic half,
                                           logic [31:0] a, logic [31:0] b);
    logic        sa, sb, na, nb, sna, snb, ns, nv;
    logic [31:0] ka, kb, r;
    if (half) begin
      sa  = a[15];
      sb  = b[15];
      na  = (a[14:10] == 5'h1f) && (a[9:0] != 10'd0);
      nb  = (b[14:10] == 5'h1f) && (b[9:0] != 10'd0);
      sna = na && !a[9];
      snb = nb && !b[9];
      ka  = {16'h0, sa ? ~a[15:0] : (a[15:0] ^ 16'h8000)};  // Total order key
      kb  = {16'h0, sb ? ~b[15:0] : (b[15:0] ^ 16'h8000)};
    end else begin
      sa  = a[31];
      sb  = b[31];
      na  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
      nb  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
      sna = na && !a[22];
      snb = nb && !b[22];
      ka  = sa ? ~a : (a ^ 32'h8000_0000);
      kb  = sb ? ~b : (b ^ 32'h8000_0000);
    end
    r  = a;
    nv = 1'b0;
    ns = sb;
    case (op)
      SGNJ:  ns = sb;
      SGNJN: ns = ~sb;
      SGNJX: ns = sa ^ sb;
      default: begin
        if (na && nb)      r = half ? {16'h0, FP16_QNAN} : FP32_QNAN;
        else if (na)       r = b;
        else if (nb)       r = a;
        else if (op == MIN) r = (ka < kb) ? a : b;
        else               r = (ka < kb) ? b : a;
        nv = sna | snb;
      end
    endcase
    if (op == SGNJ || op == SGNJN || op == SGNJX) begin
      if (half) r[15] = ns;
      else      r[31] = ns;
    end
    return {nv, r};
  endfunction

  function automatic logic [36:0] expect_word(fp_op_e op, fp_fmt_e fmt, logic vec,
                                              logic [31:0] a, logic [31:0] b);
    logic [32:0] lo, hi;
    logic [31:0] res;
    logic        nv;
    if (fmt == FP32) begin
      lo  = lane_ref(op, 1'b0, a, b);
      res = lo[31:0];
      nv  = lo[32];
    end else begin
      lo = lane_ref(op, 1'b1, {16'h0, a[15:0]}, {16'h0, b[15:0]});
      hi = lane_ref(op, 1'b1, {16'h0, a[31:16]}, {16'h0, b[31:16]});
      res = vec ? {hi[15:0], lo[15:0]} : {FP16_BOX, lo[15:0]};  // Scalar is boxed
      nv  = vec ? (lo[32] | hi[32]) : lo[32];
    end
    return {nv, 4'b0000, res};
  endfunction

  always @(posedge clk_i) begin : compare
    logic [36:0] expected;
    if (!rst_n_i) begin
      expect_q.delete();
      errors_o  = 0;
      checked_o = 0;
    end else begin
      if (expect_q.size() != 0 && busy_i !== 1'b1) begin
        $display("mismatch at %0t: busy_o is not high while %0d items are outstanding",
                 $time, expect_q.size());
        errors_o++;
      end
      if (in_valid_i && in_ready_i)
        expect_q.push_back(expect_word(op_i, fmt_i, vectorial_i, operand_a_i, operand_b_i));
      if (out_valid_i && out_ready_i) begin
        if (expect_q.size() == 0) begin
          $display("error at %0t: an item came out that was never sent", $time);
          errors_o++;
        end else begin
          expected = expect_q.pop_front();
          if ({status_i, result_i} !== expected) begin
            $display("mismatch at %0t: item %0d expected %h status %b, got %h status %b",
                     $time, checked_o, expected[31:0], expected[36:32], result_i, status_i);
            errors_o++;
          end
          checked_o++;
        end
      end
    end
    pending_o = expect_q.size();
  end

endmodule

`default_nettype wire

// File: tb_fp_simd_slice.sv
// ---------------------------------------------------------------------
// Testbench top for the SIMD slice.
// Drives random FP32 and FP16 items through the DUT in six tests,
// lets the checker compare them and prints the final report.
// ---------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_fp_simd_slice;
  import fp_fmt_pkg::*;
  import fp_op_pkg::*;

  localparam int NUM_TESTS      = 6;
  localparam int MAX_ITEMS      = 300;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_ITEMS * 11 + 200;  // Stalls and gaps

  logic     clk_i, rst_n_i, in_valid_i, in_ready_o, vectorial_i;
  logic     out_valid_o, out_ready_i, busy_o;
  fp_op_e   op_i;
  fp_fmt_e  fmt_i;
  fp_word_u operand_a_i, operand_b_i, result_o;
  status_t  status_o;
  logic     random_flow;
  int       errors, checked, pending, idle_errors, sent, total;
  int       cycles = 0;

  fp_simd_slice #(.NumPipeRegs(2)) dut (.*);

  fp_slice_checker i_slice_check (
    .clk_i, .rst_n_i, .in_valid_i, .in_ready_i(in_ready_o), .op_i, .fmt_i, .vectorial_i,
    .operand_a_i, .operand_b_i, .out_valid_i(out_valid_o), .out_ready_i,
    .result_i(result_o), .status_i(status_o), .busy_i(busy_o),
    .errors_o(errors), .checked_o(checked), .pending_o(pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Downstream back-pressure is random only in the flow test
  initial begin
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      out_ready_i <= random_flow ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // Random value with injected qNaN, sNaN, signed zero and infinity
  function automatic logic [15:0] random_fp16();
    logic [15:0] v;
    logic        s;
    s = 1'($urandom);
    v = 16'($urandom);
    case ($urandom_range(0, 7))
      0: v = {s, 5'h1f, 1'b1, 9'($urandom)};
      1: v = {s, 5'h1f, 1'b0, 9'($urandom_range(1, 511))};
      2: v = {s, 15'h0};
      3: v = {s, 5'h1f, 10'h0};
      default: ;
    endcase
    return v;
  endfunction

  function automatic logic [31:0] random_word(fp_fmt_e fmt);
    logic [31:0] v;
    logic        s;
    if (fmt == FP16) return {random_fp16(), random_fp16()};
    s = 1'($urandom);
    v = $urandom;
    case ($urandom_range(0, 7))
      0: v = {s, 8'hff, 1'b1, 22'($urandom)};
      1: v = {s, 8'hff, 1'b0, 22'($urandom_range(1, 4194303))};
      2: v = {s, 31'h0};
      3: v = {s, 8'hff, 23'h0};
      default: ;
    endcase
    return v;
  endfunction

  // op_set 0 sign injection, 1 min/max, 2 all; fmt_mode 0 FP32, 1 scalar, 2 vector, 3 any
  task automatic run_items(string name, int count, int op_set, int fmt_mode, logic flow);
    int      err0, chk0;
    fp_fmt_e fmt;
    logic    take;
    err0 = errors;
    chk0 = checked;
    random_flow = flow;
    for (int i = 0; i < count; i++) begin
      if (flow && $urandom_range(0, 3) == 0) begin
        in_valid_i <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge clk_i);
      end
      fmt = (fmt_mode == 0) ? FP32 : (fmt_mode == 3) ? fp_fmt_e'(1'($urandom)) : FP16;
      in_valid_i  <= 1'b1;
      fmt_i       <= fmt;
      vectorial_i <= (fmt_mode == 2) ? 1'b1 : (fmt_mode == 1) ? 1'b0 : 1'($urandom);
      operand_a_i <= random_word(fmt);
      operand_b_i <= random_word(fmt);
      case (op_set)
        0:       op_i <= fp_op_e'(3'($urandom_range(0, 2)));
        1:       op_i <= fp_op_e'(3'($urandom_range(3, 4)));
        default: op_i <= fp_op_e'(3'($urandom_range(0, 4)));
      endcase
      do begin
        @(negedge clk_i);
        take = in_ready_o;
        @(posedge clk_i);
      end while (!take);
    end
    in_valid_i <= 1'b0;
    do @(negedge clk_i); while (pending != 0);  // Drain
    random_flow = 1'b0;
    @(posedge clk_i);
    sent += count;
    $display("test %s: %0d items, %0d errors", name, checked - chk0, errors - err0);
  endtask

  initial begin : main
    void'($urandom(48507));
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = SGNJ;
    fmt_i       = FP32;
    vectorial_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    random_flow = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      if (out_valid_o !== 1'b0 || busy_o !== 1'b0) begin
        $display("mismatch at %0t: out_valid_o or busy_o is not low before any input",
                 $time);
        idle_errors++;
      end
    end
    @(posedge clk_i);
    $display("test reset_idle: 4 cycles watched, %0d errors", idle_errors);
    run_items("sgnj_fp32", 250, 0, 0, 1'b0);
    run_items("scalar_fp16", 250, 2, 1, 1'b0);
    run_items("vector_fp16", 250, 2, 2, 1'b0);
    run_items("minmax_nan", 300, 1, 3, 1'b0);
    run_items("random_flow", 300, 2, 3, 1'b1);
    total = errors + idle_errors;
    if (checked != sent) begin
      $display("error: %0d items were sent but %0d came out", sent, checked);
      total++;
    end
    $display("summary: %0d tests, %0d items checked, %0d errors", NUM_TESTS, checked, total);
    if (total == 0) $display("All tests passed!");
    else            $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: fp_simd_slice.f
fp_fmt_pkg.sv
fp_op_pkg.sv
fp_pipe.sv
fp_noncomp_lane.sv
fp_simd_slice.sv
fp_slice_checker.sv
tb_fp_simd_slice.sv

// File: Makefile
# Verilator build and run of the SIMD slice testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass only on the pass message"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_fp_simd_slice -f fp_simd_slice.f
	@out="$$(./obj_dir/Vtb_fp_simd_slice)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
